/* stepper_macros.svh */
`ifndef STEPPER_MACROS_SVH
`define STEPPER_MACROS_SVH

// datapath widths
`define STEP_PHASE_W 8
`define STEP_INDEX_W 6
`define STEP_PWM_W 8

// timer counter widths
`define STEP_OFF_W 10
`define STEP_BLANK_W 8

// chopper timing in clk cycles
`define STEP_OFF_TIME 810
`define STEP_FAST_TIME 104
`define STEP_BLANK_TIME 27

// charge pump half period in clk cycles
`define STEP_CP_DIV 16

`endif

/* stepper_pkg.sv */
`include "stepper_macros.svh"

package stepper_pkg;

  typedef logic [`STEP_PHASE_W-1:0] phase_t;     // electrical phase, 256 microsteps
  typedef logic [`STEP_INDEX_W-1:0] cos_index_t; // quarter-wave table address
  typedef logic [`STEP_PWM_W-1:0]   pwm_t;       // current magnitude
  typedef logic [`STEP_OFF_W-1:0]   off_time_t;
  typedef logic [`STEP_BLANK_W-1:0] blank_time_t;

  typedef struct packed {
    logic       polarity; // 1 = positive
    cos_index_t index;
  } coil_cmd_t;

  typedef struct packed {
    logic leg1_h;
    logic leg1_l;
    logic leg2_h;
    logic leg2_l;
  } coil_gate_t;

  typedef enum logic [1:0] {
    DRIVE,
    FAST,
    SLOW
  } chop_state_t;

endpackage

/* microstep_sequencer.sv */
`timescale 1ns/1ps

module microstep_sequencer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   step,
  input  logic                   dir,
  output stepper_pkg::coil_cmd_t cmd_a,
  output stepper_pkg::coil_cmd_t cmd_b
);

  logic [1:0]          step_sync;
  logic [1:0]          dir_sync;
  logic                step_prev;
  logic                step_rise;
  logic                dir_q;
  stepper_pkg::phase_t phase;
  logic [1:0]          quad;
  stepper_pkg::cos_index_t k;

  // two-flop synchronizers, then the registered edge pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      step_sync <= '0;
      dir_sync  <= '0;
      step_prev <= 1'b0;
      step_rise <= 1'b0;
      dir_q     <= 1'b0;
    end else begin
      step_sync <= {step_sync[0], step};
      dir_sync  <= {dir_sync[0], dir};
      step_prev <= step_sync[1];
      step_rise <= step_sync[1] & ~step_prev;
      dir_q     <= dir_sync[1]; // stays aligned with step_rise
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= '0;
    end else if (step_rise) begin
      phase <= dir_q ? phase + stepper_pkg::phase_t'(1) : phase - stepper_pkg::phase_t'(1);
    end
  end

  assign quad = phase[7:6];
  assign k    = phase[5:0];

  // odd quadrants run the quarter table backwards (63 - k)
  assign cmd_a.index    = quad[0] ? ~k : k;
  assign cmd_a.polarity = ~(quad[1] ^ quad[0]); // positive in q0 and q3
  assign cmd_b.index    = quad[0] ? k : ~k;
  assign cmd_b.polarity = ~quad[1];             // positive in q0 and q1

endmodule

/* cosine_lut.sv */
`timescale 1ns/1ps

module cosine_lut (
  input  stepper_pkg::cos_index_t index,
  output stepper_pkg::pwm_t       value
);

  // round(255 * cos(i * pi / 128))
  always_comb begin
    value = '0;
    case (index)
      6'd0:  value = 8'd255;
      6'd1:  value = 8'd255;
      6'd2:  value = 8'd255;
      6'd3:  value = 8'd254;
      6'd4:  value = 8'd254;
      6'd5:  value = 8'd253;
      6'd6:  value = 8'd252;
      6'd7:  value = 8'd251;
      6'd8:  value = 8'd250;
      6'd9:  value = 8'd249;
      6'd10: value = 8'd247;
      6'd11: value = 8'd246;
      6'd12: value = 8'd244;
      6'd13: value = 8'd242;
      6'd14: value = 8'd240;
      6'd15: value = 8'd238;
      6'd16: value = 8'd236;
      6'd17: value = 8'd233;
      6'd18: value = 8'd231;
      6'd19: value = 8'd228;
      6'd20: value = 8'd225;
      6'd21: value = 8'd222;
      6'd22: value = 8'd219;
      6'd23: value = 8'd215;
      6'd24: value = 8'd212;
      6'd25: value = 8'd208;
      6'd26: value = 8'd205;
      6'd27: value = 8'd201;
      6'd28: value = 8'd197;
      6'd29: value = 8'd193;
      6'd30: value = 8'd189;
      6'd31: value = 8'd185;
      6'd32: value = 8'd180;
      6'd33: value = 8'd176;
      6'd34: value = 8'd171;
      6'd35: value = 8'd167;
      6'd36: value = 8'd162;
      6'd37: value = 8'd157;
      6'd38: value = 8'd152;
      6'd39: value = 8'd147;
      6'd40: value = 8'd142;
      6'd41: value = 8'd136;
      6'd42: value = 8'd131;
      6'd43: value = 8'd126;
      6'd44: value = 8'd120;
      6'd45: value = 8'd115;
      6'd46: value = 8'd109;
      6'd47: value = 8'd103;
      6'd48: value = 8'd98;
      6'd49: value = 8'd92;
      6'd50: value = 8'd86;
      6'd51: value = 8'd80;
      6'd52: value = 8'd74;
      6'd53: value = 8'd68;
      6'd54: value = 8'd62;
      6'd55: value = 8'd56;
      6'd56: value = 8'd50;
      6'd57: value = 8'd44;
      6'd58: value = 8'd37;
      6'd59: value = 8'd31;
      6'd60: value = 8'd25;
      6'd61: value = 8'd19;
      6'd62: value = 8'd13;
      6'd63: value = 8'd6;
      default: value = '0;
    endcase
  end

endmodule

/* reference_pwm.sv */
`timescale 1ns/1ps

module reference_pwm (
  input  logic              clk,
  input  logic              rst,
  input  stepper_pkg::pwm_t level_a,
  input  stepper_pkg::pwm_t level_b,
  output logic              ref_a,
  output logic              ref_b
);

  stepper_pkg::pwm_t cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + stepper_pkg::pwm_t'(1); // wraps every 256 cycles
    end
  end

  // high for exactly level cycles per period
  always_ff @(posedge clk) begin
    if (rst) begin
      ref_a <= 1'b0;
      ref_b <= 1'b0;
    end else begin
      ref_a <= (cnt < level_a);
      ref_b <= (cnt < level_b);
    end
  end

endmodule

/* coil_chopper.sv */
`timescale 1ns/1ps
`include "stepper_macros.svh"

module coil_chopper (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    enable,
  input  logic                    polarity,
  input  logic                    cmp,
  output stepper_pkg::coil_gate_t gate
);

  logic                     pol_q;
  logic                     trip;
  stepper_pkg::blank_time_t blank;
  stepper_pkg::off_time_t   off_cnt;
  stepper_pkg::off_time_t   off_nxt;
  stepper_pkg::chop_state_t state;
  stepper_pkg::chop_state_t state_nxt;

  function automatic stepper_pkg::coil_gate_t encode_gate(
    input stepper_pkg::chop_state_t st,
    input logic                     pol
  );
    stepper_pkg::coil_gate_t g;
    g = '0;
    case (st)
      stepper_pkg::DRIVE: begin
        if (pol) {g.leg1_h, g.leg2_l} = 2'b11;
        else     {g.leg2_h, g.leg1_l} = 2'b11;
      end
      stepper_pkg::FAST: begin // reverse pair, current decays into the supply
        if (pol) {g.leg2_h, g.leg1_l} = 2'b11;
        else     {g.leg1_h, g.leg2_l} = 2'b11;
      end
      stepper_pkg::SLOW: {g.leg1_l, g.leg2_l} = 2'b11; // both low sides recirculate
      default: g = '0;
    endcase
    return g;
  endfunction

  assign trip = cmp && (blank == '0);

  // blanking restarts on every polarity change
  always_ff @(posedge clk) begin
    if (rst) begin
      pol_q <= 1'b1; // phase 0 is positive on both coils
      blank <= '0;
    end else begin
      pol_q <= polarity;
      if (polarity != pol_q) begin
        blank <= stepper_pkg::blank_time_t'(`STEP_BLANK_TIME);
      end else if (blank != '0) begin
        blank <= blank - stepper_pkg::blank_time_t'(1);
      end
    end
  end

  always_comb begin
    state_nxt = state;
    off_nxt   = off_cnt;
    case (state)
      stepper_pkg::DRIVE: begin
        if (trip) begin
          state_nxt = stepper_pkg::FAST;
          off_nxt   = stepper_pkg::off_time_t'(`STEP_OFF_TIME - 1);
        end
      end
      stepper_pkg::FAST: begin
        off_nxt = off_cnt - stepper_pkg::off_time_t'(1);
        if (off_cnt == stepper_pkg::off_time_t'(`STEP_OFF_TIME - `STEP_FAST_TIME))
          state_nxt = stepper_pkg::SLOW;
      end
      stepper_pkg::SLOW: begin
        if (off_cnt == '0) state_nxt = stepper_pkg::DRIVE;
        else               off_nxt   = off_cnt - stepper_pkg::off_time_t'(1);
      end
      default: state_nxt = stepper_pkg::DRIVE;
    endcase
  end

  // gate register follows the next state so it lines up with state
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= stepper_pkg::DRIVE;
      off_cnt <= '0;
      gate    <= '0;
    end else begin
      state   <= state_nxt;
      off_cnt <= off_nxt;
      gate    <= enable ? encode_gate(state_nxt, polarity) : '0;
    end
  end

endmodule

/* charge_pump.sv */
`timescale 1ns/1ps
`include "stepper_macros.svh"

module charge_pump (
  input  logic clk,
  input  logic rst,
  output logic pump
);

  logic [3:0] div_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      div_cnt <= '0;
      pump    <= 1'b0;
    end else begin
      div_cnt <= div_cnt + 4'd1;
      if (div_cnt == 4'(`STEP_CP_DIV - 1)) begin
        pump <= ~pump; // half period is STEP_CP_DIV cycles
      end
    end
  end

endmodule

/* stepper_driver_top.sv */
`timescale 1ns/1ps

module stepper_driver_top (
  input  logic       clk,
  input  logic       rst,
  input  logic       step,
  input  logic       dir,
  input  logic       enable,
  input  logic       analog_cmp1,
  input  logic       analog_cmp2,
  output logic [3:0] s_h,
  output logic [3:0] s_l,
  output logic       analog_out1,
  output logic       analog_out2,
  output logic       chargepump_pin
);

  stepper_pkg::coil_cmd_t  cmd_a;
  stepper_pkg::coil_cmd_t  cmd_b;
  stepper_pkg::pwm_t       mag_a;
  stepper_pkg::pwm_t       mag_b;
  stepper_pkg::coil_gate_t gate_a;
  stepper_pkg::coil_gate_t gate_b;

  microstep_sequencer u_seq (
    .clk   (clk),
    .rst   (rst),
    .step  (step),
    .dir   (dir),
    .cmd_a (cmd_a),
    .cmd_b (cmd_b)
  );

  cosine_lut u_lut_a (.index(cmd_a.index), .value(mag_a));
  cosine_lut u_lut_b (.index(cmd_b.index), .value(mag_b));

  reference_pwm u_pwm (
    .clk     (clk),
    .rst     (rst),
    .level_a (mag_a),
    .level_b (mag_b),
    .ref_a   (analog_out1),
    .ref_b   (analog_out2)
  );

  coil_chopper u_chop_a (
    .clk      (clk),
    .rst      (rst),
    .enable   (enable),
    .polarity (cmd_a.polarity),
    .cmp      (analog_cmp1),
    .gate     (gate_a)
  );

  coil_chopper u_chop_b (
    .clk      (clk),
    .rst      (rst),
    .enable   (enable),
    .polarity (cmd_b.polarity),
    .cmp      (analog_cmp2),
    .gate     (gate_b)
  );

  charge_pump u_cp (.clk(clk), .rst(rst), .pump(chargepump_pin));

  // bit order is A leg1, A leg2, B leg1, B leg2
  assign s_h = {gate_b.leg2_h, gate_b.leg1_h, gate_a.leg2_h, gate_a.leg1_h};
  assign s_l = {gate_b.leg2_l, gate_b.leg1_l, gate_a.leg2_l, gate_a.leg1_l};

endmodule

/* stepper_assert.sv */
`timescale 1ns/1ps

module stepper_assert (
  input logic       clk,
  input logic       rst,
  input logic       enable,
  input logic [3:0] s_h,
  input logic [3:0] s_l,
  input logic       analog_out1,
  input logic       analog_out2
);

  int fail_cnt = 0;

  no_shoot_through: assert property (@(posedge clk) disable iff (rst) (s_h & s_l) == 4'b0000)
    else begin
      $error("high and low gate of one leg on together");
      fail_cnt++;
    end

  off_when_disabled: assert property (@(posedge clk) disable iff (rst)
    !enable |=> (s_h == 4'b0000) && (s_l == 4'b0000))
    else begin
      $error("gates on in the cycle after enable was low");
      fail_cnt++;
    end

  refs_known: assert property (@(posedge clk) disable iff (rst)
    !$isunknown({analog_out1, analog_out2}))
    else begin
      $error("current reference output unknown");
      fail_cnt++;
    end

endmodule

bind stepper_driver_top stepper_assert u_assert (.*);

/* tb_stepper_driver.sv */
`timescale 1ns/1ps
`include "stepper_macros.svh"

module tb_stepper_driver;

  logic                    clk = 1'b0;
  logic                    rst, step, dir, enable, analog_cmp1, analog_cmp2;
  logic [3:0]              s_h, s_l;
  logic                    analog_out1, analog_out2, chargepump_pin;
  stepper_pkg::coil_gate_t gate_a, gate_b;
  stepper_pkg::phase_t     model_phase;

  stepper_driver_top uut (.*);

  assign gate_a = {s_h[0], s_l[0], s_h[1], s_l[1]};
  assign gate_b = {s_h[2], s_l[2], s_h[3], s_l[3]};

  always #50 clk = ~clk;

  // reference model of the quadrant mapping and the table
  function automatic logic pol_a(input stepper_pkg::phase_t p);
    return (p[7:6] == 2'd0) || (p[7:6] == 2'd3);
  endfunction

  function automatic logic pol_b(input stepper_pkg::phase_t p);
    return p[7:6] < 2'd2;
  endfunction

  function automatic stepper_pkg::cos_index_t index_a(input stepper_pkg::phase_t p);
    return p[6] ? stepper_pkg::cos_index_t'(63 - p[5:0]) : p[5:0]; // q1, q3 run backwards
  endfunction

  function automatic stepper_pkg::cos_index_t index_b(input stepper_pkg::phase_t p);
    return p[6] ? p[5:0] : stepper_pkg::cos_index_t'(63 - p[5:0]);
  endfunction

  function automatic stepper_pkg::pwm_t cos_mag(input stepper_pkg::cos_index_t i);
    real r;
    r = 255.0 * $cos(3.141592653589793 * i / 128.0);
    return stepper_pkg::pwm_t'($rtoi(r + 0.5));
  endfunction

  function automatic stepper_pkg::coil_gate_t expected_gate(input stepper_pkg::chop_state_t st,
                                                            input logic pos);
    stepper_pkg::coil_gate_t g;
    g = '0;
    if (st == stepper_pkg::SLOW) begin
      g.leg1_l = 1'b1;
      g.leg2_l = 1'b1;
    end else if ((st == stepper_pkg::DRIVE) == pos) begin // drive positive or fast negative
      g.leg1_h = 1'b1;
      g.leg2_l = 1'b1;
    end else begin
      g.leg2_h = 1'b1;
      g.leg1_l = 1'b1;
    end
    return g;
  endfunction

  task automatic tick();
    @(posedge clk);
    #5;
  endtask

  task automatic idle(input int n);
    repeat (n) tick();
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "run stopped");
  endtask

  always @(posedge clk) begin
    if (uut.u_assert.fail_cnt != 0) abort_run("a gate or output assertion failed");
  end

  task automatic check_pwm(input string name, input stepper_pkg::pwm_t exp,
                           input stepper_pkg::pwm_t act);
    if (act !== exp) abort_run($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
  endtask

  task automatic check_gate(input string name, input stepper_pkg::coil_gate_t exp,
                            input stepper_pkg::coil_gate_t act);
    if (act !== exp) abort_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) abort_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
  endtask

  task automatic check_count(input string name, input stepper_pkg::off_time_t exp,
                             input stepper_pkg::off_time_t act);
    if (act !== exp) abort_run($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
  endtask

  // one step pulse, phase moves on the 4th edge after it is driven
  task automatic do_step();
    step = 1'b1;
    idle(2);
    step = 1'b0;
    idle(2);
    model_phase = dir ? model_phase + 8'd1 : model_phase - 8'd1;
  endtask

  task automatic step_to(input stepper_pkg::phase_t target);
    int n;
    n = 0;
    while (model_phase != target) begin
      do_step();
      n++;
      if (n > 300) abort_run("step count ran away before reaching the target phase");
    end
  endtask

  task automatic check_drive(input string name);
    check_gate(name, expected_gate(stepper_pkg::DRIVE, pol_a(model_phase)), gate_a);
    check_gate(name, expected_gate(stepper_pkg::DRIVE, pol_b(model_phase)), gate_b);
  endtask

  task automatic reset_and_disable();
    repeat (8) begin
      check_gate("disabled_a", '0, gate_a);
      check_gate("disabled_b", '0, gate_b);
      check_bit("cp_after_reset", 1'b0, chargepump_pin);
      tick();
    end
    enable = 1'b1;
    idle(2);
    check_drive("enable_phase0");
  endtask

  task automatic step_bursts();
    int n;
    int ha;
    int hb;
    repeat (6) begin
      dir = ~dir; // bursts alternate between down and up
      idle(4);
      n = 1 + $urandom % 40;
      repeat (n) do_step();
      idle(4);
      ha = 0;
      hb = 0;
      repeat (256) begin
        ha += int'(analog_out1);
        hb += int'(analog_out2);
        tick();
      end
      check_pwm("microstep_a", cos_mag(index_a(model_phase)), stepper_pkg::pwm_t'(ha));
      check_pwm("microstep_b", cos_mag(index_b(model_phase)), stepper_pkg::pwm_t'(hb));
    end
  endtask

  task automatic cross_quadrants();
    stepper_pkg::phase_t bounds [4];
    bounds = '{8'd64, 8'd128, 8'd192, 8'd0};
    dir = 1'b1;
    idle(4);
    foreach (bounds[i]) begin
      step_to(stepper_pkg::phase_t'(bounds[i] - 8'd1));
      idle(2);
      check_drive("before_boundary");
      do_step();
      idle(2);
      check_drive("after_boundary");
    end
  endtask

  task automatic chop_coil_a();
    stepper_pkg::coil_gate_t drive_b;
    int n;
    idle(40); // blanking long expired
    drive_b = expected_gate(stepper_pkg::DRIVE, pol_b(model_phase));
    analog_cmp1 = 1'b1;
    tick();
    analog_cmp1 = 1'b0;
    check_gate("chop_fast", expected_gate(stepper_pkg::FAST, pol_a(model_phase)), gate_a);
    n = 0;
    while (gate_a === expected_gate(stepper_pkg::FAST, pol_a(model_phase))) begin
      check_gate("chop_coil_b", drive_b, gate_b);
      n++;
      if (n > 1000) abort_run("coil A never left fast decay");
      tick();
    end
    check_count("chop_fast_len", `STEP_FAST_TIME, stepper_pkg::off_time_t'(n));
    check_gate("chop_slow", expected_gate(stepper_pkg::SLOW, pol_a(model_phase)), gate_a);
    n = 0;
    while (gate_a === expected_gate(stepper_pkg::SLOW, pol_a(model_phase))) begin
      check_gate("chop_coil_b", drive_b, gate_b);
      n++;
      if (n > 1000) abort_run("coil A never left slow decay");
      tick();
    end
    check_count("chop_slow_len", `STEP_OFF_TIME - `STEP_FAST_TIME, stepper_pkg::off_time_t'(n));
    check_drive("chop_back_to_drive");
  endtask

  task automatic blank_coil_b();
    int n;
    dir = 1'b1;
    idle(4);
    step_to(8'd127);
    idle(40);
    do_step(); // coil B turns negative at 128
    n = 0;
    while (gate_b !== expected_gate(stepper_pkg::DRIVE, pol_b(model_phase))) begin
      n++;
      if (n > 20) abort_run("coil B gates did not follow the polarity change");
      tick();
    end
    idle(3);
    analog_cmp2 = 1'b1;
    tick();
    analog_cmp2 = 1'b0;
    repeat (40) begin
      check_gate("blank_b", expected_gate(stepper_pkg::DRIVE, pol_b(model_phase)), gate_b);
      tick();
    end
  endtask

  task automatic wait_toggle(output int n);
    logic prev;
    prev = chargepump_pin;
    n = 0;
    while (chargepump_pin === prev) begin
      tick();
      n++;
      if (n > 64) abort_run("charge pump pin stopped toggling");
    end
  endtask

  task automatic pump_period();
    int n;
    wait_toggle(n);
    repeat (3) begin
      wait_toggle(n);
      check_count("cp_half_period", `STEP_CP_DIV, stepper_pkg::off_time_t'(n));
    end
  endtask

  initial begin
    void'($urandom(32'h58454041));
    rst = 1'b1;
    step = 1'b0;
    dir = 1'b1;
    enable = 1'b0;
    analog_cmp1 = 1'b0;
    analog_cmp2 = 1'b0;
    model_phase = '0;
    idle(2);
    rst = 1'b0;
    reset_and_disable();
    step_bursts();
    cross_quadrants();
    chop_coil_a();
    blank_coil_b();
    pump_period();
    if (uut.u_assert.fail_cnt == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      abort_run("gate or output assertions failed during the run");
    end
  end

endmodule

/* src.f */
+incdir+.
stepper_pkg.sv
microstep_sequencer.sv
cosine_lut.sv
reference_pwm.sv
coil_chopper.sv
charge_pump.sv
stepper_driver_top.sv
stepper_assert.sv
tb_stepper_driver.sv
